//--- cpu_cfg.svh
// ##############################
// width and field macros for the pipelined core
// register file size and link register
// reset PC and PC step
// ##############################
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath word and register index
`define WORD_WIDTH      32
`define REG_COUNT       32
`define REG_ADDR_WIDTH  5

// instruction field widths
`define OPCODE_WIDTH    5
`define ALU_OP_WIDTH    5
`define IMM_WIDTH       17
`define TARGET_WIDTH    27

// jal writes its return address here
`define LINK_REG        31

// first fetch address after reset
`define RESET_PC        32'd0
// instruction memory is word addressed
`define PC_STEP         32'd1

`endif

//--- cpuPkg.sv
// ##############################
// shared types of the core
// word and register index types
// opcode, ALU and select enums
// ##############################
`default_nettype none
`include "cpu_cfg.svh"

package cpuPkg;

    typedef logic [`WORD_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] regIdx_t;

    // major opcode in bits 31 to 27
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opR    = 5'd0,
        opJ    = 5'd1,
        opBne  = 5'd2,
        opJal  = 5'd3,
        opJr   = 5'd4,
        opAddi = 5'd5,
        opBlt  = 5'd6,
        opSw   = 5'd7,
        opLw   = 5'd8
    } opcode_e;

    // R-type function field in bits 6 to 2
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        aluAdd = 5'd0,
        aluSub = 5'd1,
        aluAnd = 5'd2,
        aluOr  = 5'd3,
        aluSll = 5'd4,
        aluSra = 5'd5
    } aluOp_e;

    typedef enum logic [1:0] {pcPlus1, pcBranch, pcTarget, pcReg} pcSel_e;

    typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSel_e;

    typedef enum logic [1:0] {fwdNone, fwdXm, fwdMw} fwdSel_e;

endpackage

`default_nettype wire

//--- pcFetch.sv
// ##############################
// fetch stage
// program counter and next-PC choice
// fetch/decode pipeline register
// ##############################
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module pcFetch import cpuPkg::*; (
    input  logic  clock,
    input  logic  rstN,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirectPc,
    input  word_t imemData,
    output word_t imemAddr,
    output word_t fdInstr,
    output word_t fdPc,
    output logic  fdValid
);

    word_t pc;

    // instruction memory answers in the same cycle
    assign imemAddr = pc;

    // redirect from execute wins, load-use hold freezes both
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc      <= `RESET_PC;
            fdValid <= 1'b0;
        end else if (redirect) begin
            pc      <= redirectPc;
            // squash the word fetched this cycle
            fdValid <= 1'b0;
        end else if (!stall) begin
            pc      <= pc + `PC_STEP;
            fdValid <= 1'b1;
        end
    end

    // fetched word and its address
    always_ff @(posedge clock) begin
        if (!stall) begin
            fdInstr <= imemData;
            fdPc    <= pc;
        end
    end

    // load in execute never redirects, target must be known
    redirectClean: assert property (@(posedge clock) disable iff (!rstN)
        redirect |-> !stall && !$isunknown(redirectPc));

endmodule

`default_nettype wire

//--- instrDecode.sv
// ##############################
// decode stage
// field split and control decode
// immediate and target extension
// read-port choice and DX register
// ##############################
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module instrDecode import cpuPkg::*; (
    input  logic                       clock,
    input  logic                       rstN,
    input  logic                       stall,
    input  logic                       flush,
    input  word_t                      fdInstr,
    input  word_t                      fdPc,
    input  word_t                      rdDataA,
    input  word_t                      rdDataB,
    input  logic                       fdValid,
    output regIdx_t                    rdAddrA,
    output regIdx_t                    rdAddrB,
    output regIdx_t                    dxSrcA,
    output regIdx_t                    dxSrcB,
    output regIdx_t                    dxDest,
    output aluOp_e                     dxAluOp,
    output logic [`REG_ADDR_WIDTH-1:0] dxShamt,
    output word_t                      dxOpA,
    output word_t                      dxOpB,
    output word_t                      dxImm,
    output word_t                      dxTarget,
    output word_t                      dxPc,
    output opcode_e                    dxOpcode,
    output logic                       dxUseImm,
    output logic                       dxRegWrite,
    output logic                       dxValid,
    output wbSel_e                     dxWbSel
);

    opcode_e opcode;
    regIdx_t rd;
    regIdx_t rs;
    regIdx_t rt;
    logic    isBranch;
    logic    bubble;
    aluOp_e  aluOp;
    logic    useImm;
    logic    regWrite;
    wbSel_e  wbSel;
    regIdx_t dest;
    word_t   immExt;
    word_t   targetPad;

    // fields
    assign opcode = opcode_e'(fdInstr[31:27]);
    assign rd     = fdInstr[26:22];
    assign rs     = fdInstr[21:17];
    assign rt     = fdInstr[16:12];

    // branches compare rd against rs
    assign isBranch = (opcode == opBne) || (opcode == opBlt);
    assign rdAddrA  = isBranch ? rd : rs;
    // sw data and jr target both sit in rd
    assign rdAddrB  = isBranch ? rs : ((opcode == opSw || opcode == opJr) ? rd : rt);

    assign immExt    = {{(`WORD_WIDTH - `IMM_WIDTH){fdInstr[`IMM_WIDTH-1]}},
                        fdInstr[`IMM_WIDTH-1:0]};
    assign targetPad = {{(`WORD_WIDTH - `TARGET_WIDTH){1'b0}}, fdInstr[`TARGET_WIDTH-1:0]};

    // control decode, j and jr only steer the PC
    always_comb begin
        aluOp    = aluAdd;
        useImm   = 1'b0;
        regWrite = 1'b0;
        wbSel    = wbAlu;
        dest     = rd;
        case (opcode)
            opR: begin
                aluOp    = aluOp_e'(fdInstr[6:2]);
                regWrite = 1'b1;
            end
            opAddi: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            opLw: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
                wbSel    = wbMem;
            end
            // store keeps its data register in dest for store forwarding
            opSw: begin
                useImm = 1'b1;
                wbSel  = wbMem;
            end
            opBne, opBlt: aluOp = aluSub;
            opJal: begin
                regWrite = 1'b1;
                wbSel    = wbLink;
                dest     = regIdx_t'(`LINK_REG);
            end
            default: ;
        endcase
    end

    // load-use hold or taken redirect inserts a bubble
    assign bubble = stall || flush || !fdValid;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            dxValid    <= 1'b0;
            dxRegWrite <= 1'b0;
            dxOpcode   <= opR;
        end else if (bubble) begin
            dxValid    <= 1'b0;
            dxRegWrite <= 1'b0;
            dxOpcode   <= opR;
        end else begin
            dxValid    <= 1'b1;
            dxRegWrite <= regWrite;
            dxOpcode   <= opcode;
        end
    end

    // operands and fields
    always_ff @(posedge clock) begin
        dxSrcA   <= rdAddrA;
        dxSrcB   <= rdAddrB;
        dxDest   <= dest;
        dxAluOp  <= aluOp;
        dxShamt  <= fdInstr[11:7];
        dxOpA    <= rdDataA;
        dxOpB    <= rdDataB;
        dxImm    <= immExt;
        dxTarget <= targetPad;
        dxPc     <= fdPc;
        dxUseImm <= useImm;
        dxWbSel  <= wbSel;
    end

endmodule

`default_nettype wire

//--- regFile.sv
// ##############################
// register file
// two read ports and one write port
// register zero reads zero
// ##############################
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module regFile import cpuPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    input  logic    wrEn,
    input  regIdx_t wrAddr,
    input  regIdx_t rdAddrA,
    input  regIdx_t rdAddrB,
    input  word_t   wrData,
    output word_t   rdDataA,
    output word_t   rdDataB
);

    word_t regs [`REG_COUNT];
    logic  wrLive;

    // writes to register zero are dropped
    assign wrLive = wrEn && (wrAddr != '0);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-through, decode sees the value retiring this cycle
    assign rdDataA = (wrLive && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrLive && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

//--- executeStage.sv
// ##############################
// execute stage
// operand forwarding and ALU
// branch and jump resolution
// execute/memory register
// ##############################
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module executeStage import cpuPkg::*; (
    input  logic                       clock,
    input  logic                       rstN,
    input  regIdx_t                    dxDest,
    input  aluOp_e                     dxAluOp,
    input  logic [`REG_ADDR_WIDTH-1:0] dxShamt,
    input  word_t                      dxOpA,
    input  word_t                      dxOpB,
    input  word_t                      dxImm,
    input  word_t                      dxTarget,
    input  word_t                      dxPc,
    input  opcode_e                    dxOpcode,
    input  logic                       dxUseImm,
    input  logic                       dxRegWrite,
    input  logic                       dxValid,
    input  wbSel_e                     dxWbSel,
    input  fwdSel_e                    fwdA,
    input  fwdSel_e                    fwdB,
    input  word_t                      mwResult,
    output logic                       redirect,
    output word_t                      redirectPc,
    output logic                       flush,
    output word_t                      xmResult,
    output word_t                      xmStoreData,
    output regIdx_t                    xmDest,
    output logic                       xmRegWrite,
    output logic                       xmMemWrite,
    output logic                       xmValid,
    output wbSel_e                     xmWbSel
);

    word_t  opA;
    word_t  opB;
    word_t  aluB;
    word_t  aluOut;
    word_t  pcNext;
    word_t  branchPc;
    logic   notEqual;
    logic   lessThan;
    pcSel_e pcSel;

    // bypass muxes
    always_comb begin
        case (fwdA)
            fwdXm:   opA = xmResult;
            fwdMw:   opA = mwResult;
            default: opA = dxOpA;
        endcase
        case (fwdB)
            fwdXm:   opB = xmResult;
            fwdMw:   opB = mwResult;
            default: opB = dxOpB;
        endcase
    end

    assign aluB = dxUseImm ? dxImm : opB;

    always_comb begin
        case (dxAluOp)
            aluAdd:  aluOut = opA + aluB;
            aluSub:  aluOut = opA - aluB;
            aluAnd:  aluOut = opA & aluB;
            aluOr:   aluOut = opA | aluB;
            aluSll:  aluOut = opA << dxShamt;
            aluSra:  aluOut = $signed(opA) >>> dxShamt;
            default: aluOut = '0;
        endcase
    end

    // branch compares use the register operands, never the immediate
    assign notEqual = opA != opB;
    assign lessThan = $signed(opA) < $signed(opB);

    assign pcNext   = dxPc + `PC_STEP;
    assign branchPc = pcNext + dxImm;

    always_comb begin
        pcSel = pcPlus1;
        if (dxValid) begin
            case (dxOpcode)
                opBne:      pcSel = notEqual ? pcBranch : pcPlus1;
                opBlt:      pcSel = lessThan ? pcBranch : pcPlus1;
                opJ, opJal: pcSel = pcTarget;
                opJr:       pcSel = pcReg;
                default:    pcSel = pcPlus1;
            endcase
        end
    end

    always_comb begin
        case (pcSel)
            pcBranch: redirectPc = branchPc;
            pcTarget: redirectPc = dxTarget;
            pcReg:    redirectPc = opB;
            default:  redirectPc = pcNext;
        endcase
    end

    // a taken redirect squashes fetch and decode
    assign redirect = pcSel != pcPlus1;
    assign flush    = redirect;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            xmValid    <= 1'b0;
            xmRegWrite <= 1'b0;
            xmMemWrite <= 1'b0;
            xmWbSel    <= wbAlu;
        end else begin
            xmValid    <= dxValid;
            xmRegWrite <= dxValid && dxRegWrite;
            xmMemWrite <= dxValid && (dxOpcode == opSw);
            xmWbSel    <= dxWbSel;
        end
    end

    // jal carries its link value in place of the ALU result
    always_ff @(posedge clock) begin
        xmResult    <= (dxWbSel == wbLink) ? pcNext : aluOut;
        xmStoreData <= opB;
        xmDest      <= dxDest;
    end

endmodule

`default_nettype wire

//--- memWriteback.sv
// ##############################
// memory stage
// data memory drive and writeback pick
// memory/writeback register
// ##############################
`timescale 1ns/10ps
`default_nettype none

module memWriteback import cpuPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    input  word_t   xmResult,
    input  word_t   xmStoreData,
    input  regIdx_t xmDest,
    input  logic    xmRegWrite,
    input  logic    xmMemWrite,
    input  logic    xmValid,
    input  wbSel_e  xmWbSel,
    input  logic    storeFwd,
    input  word_t   dmemRdata,
    output word_t   dmemAddr,
    output word_t   dmemWdata,
    output logic    dmemWren,
    output word_t   mwResult,
    output regIdx_t mwDest,
    output logic    mwRegWrite
);

    // ALU result is the effective address
    assign dmemAddr  = xmResult;
    // store data straight from the value retiring in writeback
    assign dmemWdata = storeFwd ? mwResult : xmStoreData;
    assign dmemWren  = xmValid && xmMemWrite;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            mwRegWrite <= 1'b0;
        end else begin
            mwRegWrite <= xmValid && xmRegWrite;
        end
    end

    // load data or the result carried from execute
    always_ff @(posedge clock) begin
        mwResult <= (xmWbSel == wbMem) ? dmemRdata : xmResult;
        mwDest   <= xmDest;
    end

    storeAddrKnown: assert property (@(posedge clock) disable iff (!rstN)
        dmemWren |-> !$isunknown(dmemAddr));

endmodule

`default_nettype wire

//--- hazardUnit.sv
// ##############################
// hazard detection
// operand forwarding selects
// store data forwarding
// load-use stall
// ##############################
`timescale 1ns/10ps
`default_nettype none

module hazardUnit import cpuPkg::*; (
    input  regIdx_t dxSrcA,
    input  regIdx_t dxSrcB,
    input  regIdx_t xmDest,
    input  regIdx_t mwDest,
    input  regIdx_t rdAddrA,
    input  regIdx_t rdAddrB,
    input  regIdx_t dxDest,
    input  logic    xmRegWrite,
    input  logic    mwRegWrite,
    input  logic    xmValid,
    input  logic    dxValid,
    input  opcode_e dxOpcode,
    input  wbSel_e  xmWbSel,
    output fwdSel_e fwdA,
    output fwdSel_e fwdB,
    output logic    storeFwd,
    output logic    stall
);

    logic xmLive;
    logic mwLive;
    logic loadInDx;

    // producers that write a real register
    assign xmLive = xmValid && xmRegWrite && (xmDest != '0);
    // mwRegWrite already includes the valid bit
    assign mwLive = mwRegWrite && (mwDest != '0);

    // younger result in XM wins over MW
    assign fwdA = (xmLive && (xmDest == dxSrcA)) ? fwdXm :
                  ((mwLive && (mwDest == dxSrcA)) ? fwdMw : fwdNone);
    assign fwdB = (xmLive && (xmDest == dxSrcB)) ? fwdXm :
                  ((mwLive && (mwDest == dxSrcB)) ? fwdMw : fwdNone);

    // load data is not ready until memory, hold decode one cycle
    assign loadInDx = dxValid && (dxOpcode == opLw) && (dxDest != '0);
    assign stall    = loadInDx && ((dxDest == rdAddrA) || (dxDest == rdAddrB));

    // store in XM has no register write and keeps its data register in xmDest
    assign storeFwd = xmValid && !xmRegWrite && (xmWbSel == wbMem) &&
                      mwLive && (mwDest == xmDest);

endmodule

`default_nettype wire

//--- cpuCore.sv
// ##############################
// five-stage pipelined core
// fetch, decode, execute, memory, writeback
// register file and hazard unit
// ##############################
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuCore import cpuPkg::*; (
    input  logic  clock,
    input  logic  rstN,
    input  word_t imemData,
    input  word_t dmemRdata,
    output word_t imemAddr,
    output word_t dmemAddr,
    output word_t dmemWdata,
    output logic  dmemWren
);

    // fetch/decode
    word_t   fdInstr, fdPc;
    logic    fdValid, stall, redirect, flush;
    word_t   redirectPc;

    // decode/execute and register file
    regIdx_t rdAddrA, rdAddrB, dxSrcA, dxSrcB, dxDest;
    word_t   rdDataA, rdDataB, dxOpA, dxOpB, dxImm, dxTarget, dxPc;
    aluOp_e  dxAluOp;
    opcode_e dxOpcode;
    wbSel_e  dxWbSel;
    logic    dxUseImm, dxRegWrite, dxValid;
    logic [`REG_ADDR_WIDTH-1:0] dxShamt;

    // execute/memory and memory/writeback
    fwdSel_e fwdA, fwdB;
    word_t   xmResult, xmStoreData, mwResult;
    regIdx_t xmDest, mwDest;
    logic    xmRegWrite, xmMemWrite, xmValid, mwRegWrite, storeFwd;
    wbSel_e  xmWbSel;

    pcFetch pcFetch_i (
        .clock, .rstN, .stall, .redirect, .redirectPc, .imemData,
        .imemAddr, .fdInstr, .fdPc, .fdValid
    );

    instrDecode instrDecode_i (
        .clock, .rstN, .stall, .flush, .fdInstr, .fdPc, .rdDataA, .rdDataB, .fdValid,
        .rdAddrA, .rdAddrB, .dxSrcA, .dxSrcB, .dxDest, .dxAluOp, .dxShamt,
        .dxOpA, .dxOpB, .dxImm, .dxTarget, .dxPc, .dxOpcode,
        .dxUseImm, .dxRegWrite, .dxValid, .dxWbSel
    );

    // writeback drives the write port
    regFile regFile_i (
        .clock, .rstN, .wrEn(mwRegWrite), .wrAddr(mwDest), .rdAddrA, .rdAddrB,
        .wrData(mwResult), .rdDataA, .rdDataB
    );

    executeStage executeStage_i (
        .clock, .rstN, .dxDest, .dxAluOp, .dxShamt, .dxOpA, .dxOpB, .dxImm,
        .dxTarget, .dxPc, .dxOpcode, .dxUseImm, .dxRegWrite, .dxValid, .dxWbSel,
        .fwdA, .fwdB, .mwResult, .redirect, .redirectPc, .flush,
        .xmResult, .xmStoreData, .xmDest, .xmRegWrite, .xmMemWrite, .xmValid, .xmWbSel
    );

    memWriteback memWriteback_i (
        .clock, .rstN, .xmResult, .xmStoreData, .xmDest, .xmRegWrite, .xmMemWrite,
        .xmValid, .xmWbSel, .storeFwd, .dmemRdata, .dmemAddr, .dmemWdata, .dmemWren,
        .mwResult, .mwDest, .mwRegWrite
    );

    hazardUnit hazardUnit_i (
        .dxSrcA, .dxSrcB, .xmDest, .mwDest, .rdAddrA, .rdAddrB, .dxDest,
        .xmRegWrite, .mwRegWrite, .xmValid, .dxValid, .dxOpcode, .xmWbSel,
        .fwdA, .fwdB, .storeFwd, .stall
    );

endmodule

`default_nettype wire

//--- cpuTb.sv
// ##############################
// testbench for the pipelined core
// instruction and data memory models
// program and expected store tables
// compare tasks for stores and fetches
// ##############################
`timescale 1ns/10ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

    localparam int PROG_LEN      = 48;
    localparam int NUM_STORES    = 14;
    localparam int FETCH_CHECKS  = 16;
    localparam int STORE_TIMEOUT = 60;
    localparam int TAIL_CYCLES   = 20;

    // preloaded words for the load tests
    localparam word_t LOAD_A = 32'h8765_4321;
    localparam word_t LOAD_B = 32'hfedc_ba98;

    logic  clock;
    logic  rstN;
    word_t imemAddr;
    word_t imemData;
    word_t dmemAddr;
    word_t dmemWdata;
    word_t dmemRdata;
    logic  dmemWren;

    word_t imem [64];
    word_t dmem [256];
    word_t progTable [PROG_LEN];
    word_t expAddr [NUM_STORES];
    word_t expData [NUM_STORES];

    // stores seen on the data bus, oldest first
    word_t addrQ [$];
    word_t dataQ [$];

    cpuCore dut_i (
        .clock, .rstN, .imemData, .dmemRdata,
        .imemAddr, .dmemAddr, .dmemWdata, .dmemWren
    );

    always #50 clock = ~clock;

    // both memories answer in the same cycle
    assign imemData  = imem[imemAddr[5:0]];
    assign dmemRdata = dmem[dmemAddr[7:0]];

    // store lands on the rising edge with dmemWren high
    always @(posedge clock) begin
        if (dmemWren) begin
            dmem[dmemAddr[7:0]] <= dmemWdata;
        end
    end

    // capture mid-cycle where the bus is settled
    always @(negedge clock) begin
        if (rstN && dmemWren) begin
            addrQ.push_back(dmemAddr);
            dataQ.push_back(dmemWdata);
        end
    end

    function automatic word_t rWord(input regIdx_t rd, input regIdx_t rs, input regIdx_t rt,
                                    input logic [4:0] shamt, input aluOp_e op);
        return {opR, rd, rs, rt, shamt, op, 2'b00};
    endfunction

    function automatic word_t iWord(input opcode_e op, input regIdx_t rd, input regIdx_t rs,
                                    input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic word_t jWord(input opcode_e op, input logic [26:0] target);
        return {op, target};
    endfunction

    function automatic word_t signExtend(input logic [16:0] v);
        return {{15{v[16]}}, v};
    endfunction

    task automatic abortRun();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkStore(input word_t gotAddr, input word_t gotData,
                              input word_t wantAddr, input word_t wantData);
        if (gotAddr !== wantAddr || gotData !== wantData) begin
            $display("mismatch at %0t: store got [%h]=%h expected [%h]=%h",
                     $time, gotAddr, gotData, wantAddr, wantData);
            abortRun();
        end
    endtask

    task automatic checkFetch(input word_t got, input word_t want);
        if (got !== want) begin
            $display("mismatch at %0t: fetch address %h expected %h", $time, got, want);
            abortRun();
        end
    endtask

    task automatic verifyWren(input logic got, input logic want);
        if (got !== want) begin
            $display("mismatch at %0t: dmemWren %b expected %b", $time, got, want);
            abortRun();
        end
    endtask

    task automatic buildProgram();
        word_t       rnd;
        logic [16:0] immA;
        logic [16:0] immB;
        word_t       rv [9];
        rnd  = $urandom();
        immA = rnd[16:0];
        rnd  = $urandom();
        immB = rnd[16:0];
        // register values of the ALU chain, 32-bit two's complement
        rv[0] = '0;
        rv[1] = signExtend(immA);
        rv[2] = rv[1] + signExtend(immB);
        rv[3] = rv[1] + rv[2];
        rv[4] = rv[3] - rv[1];
        rv[5] = rv[4] & rv[2];
        rv[6] = rv[5] | rv[1];
        rv[7] = rv[6] << 3;
        rv[8] = $signed(rv[4]) >>> 5;
        // back-to-back chain, each op uses the previous one or two results
        progTable[0] = iWord(opAddi, 5'd1, 5'd0, immA);
        progTable[1] = iWord(opAddi, 5'd2, 5'd1, immB);
        progTable[2] = rWord(5'd3, 5'd1, 5'd2, 5'd0, aluAdd);
        progTable[3] = rWord(5'd4, 5'd3, 5'd1, 5'd0, aluSub);
        progTable[4] = rWord(5'd5, 5'd4, 5'd2, 5'd0, aluAnd);
        progTable[5] = rWord(5'd6, 5'd5, 5'd1, 5'd0, aluOr);
        progTable[6] = rWord(5'd7, 5'd6, 5'd0, 5'd3, aluSll);
        progTable[7] = rWord(5'd8, 5'd4, 5'd0, 5'd5, aluSra);
        for (int i = 0; i < 8; i++) begin
            progTable[8 + i] = iWord(opSw, regIdx_t'(i + 1), 5'd0, 17'(100 + i));
            expAddr[i]       = word_t'(100 + i);
            expData[i]       = rv[i + 1];
        end
        // load-use pair, then store of a just-loaded register
        progTable[16] = iWord(opLw, 5'd10, 5'd0, 17'd200);
        progTable[17] = rWord(5'd11, 5'd10, 5'd1, 5'd0, aluAdd);
        progTable[18] = iWord(opSw, 5'd11, 5'd0, 17'd108);
        progTable[19] = iWord(opLw, 5'd12, 5'd0, 17'd201);
        progTable[20] = iWord(opSw, 5'd12, 5'd0, 17'd109);
        // r13 = 5, r14 = -3
        progTable[21] = iWord(opAddi, 5'd13, 5'd0, 17'd5);
        progTable[22] = iWord(opAddi, 5'd14, 5'd0, 17'h1fffd);
        // taken bne and blt, the two slots behind each must vanish
        progTable[23] = iWord(opBne, 5'd13, 5'd14, 17'd2);
        progTable[24] = iWord(opSw, 5'd13, 5'd0, 17'd150);
        progTable[25] = iWord(opSw, 5'd14, 5'd0, 17'd151);
        progTable[26] = iWord(opBlt, 5'd14, 5'd13, 17'd2);
        progTable[27] = iWord(opSw, 5'd13, 5'd0, 17'd152);
        progTable[28] = iWord(opSw, 5'd13, 5'd0, 17'd153);
        // not taken, falls through to the stores
        progTable[29] = iWord(opBne, 5'd13, 5'd13, 17'd5);
        progTable[30] = iWord(opBlt, 5'd13, 5'd14, 17'd5);
        progTable[31] = iWord(opSw, 5'd14, 5'd0, 17'd110);
        progTable[32] = iWord(opSw, 5'd13, 5'd0, 17'd111);
        // j over two slots, jal out to a jr that returns to 37
        progTable[33] = jWord(opJ, 27'd36);
        progTable[34] = iWord(opSw, 5'd13, 5'd0, 17'd154);
        progTable[35] = iWord(opSw, 5'd13, 5'd0, 17'd155);
        progTable[36] = jWord(opJal, 27'd40);
        progTable[37] = iWord(opSw, 5'd31, 5'd0, 17'd112);
        progTable[38] = jWord(opJ, 27'd45);
        progTable[39] = iWord(opSw, 5'd13, 5'd0, 17'd156);
        progTable[40] = iWord(opJr, 5'd31, 5'd0, 17'd0);
        for (int i = 41; i < 45; i++) begin
            progTable[i] = iWord(opSw, 5'd13, 5'd0, 17'(116 + i));
        end
        // write to r0 must read back as zero
        progTable[45] = iWord(opAddi, 5'd0, 5'd0, 17'd77);
        progTable[46] = iWord(opSw, 5'd0, 5'd0, 17'd113);
        progTable[47] = jWord(opJ, 27'd47);
        expAddr[8]  = 32'd108;
        expData[8]  = LOAD_A + rv[1];
        expAddr[9]  = 32'd109;
        expData[9]  = LOAD_B;
        expAddr[10] = 32'd110;
        expData[10] = 32'hffff_fffd;
        expAddr[11] = 32'd111;
        expData[11] = 32'd5;
        // link value of jal at 36
        expAddr[12] = 32'd112;
        expData[12] = 32'd37;
        expAddr[13] = 32'd113;
        expData[13] = 32'd0;
    endtask

    initial begin
        word_t gotAddr;
        word_t gotData;
        int    waited;
        clock = 1'b0;
        rstN  = 1'b0;
        void'($urandom(32'h7cdc5359));
        // spare slots jump to themselves
        for (int a = 0; a < 64; a++) begin
            imem[a] = jWord(opJ, 27'(a));
        end
        for (int a = 0; a < 256; a++) begin
            dmem[a] <= 32'hd0d0_0000 | word_t'(a);
        end
        dmem[200] <= LOAD_A;
        dmem[201] <= LOAD_B;
        buildProgram();
        for (int a = 0; a < PROG_LEN; a++) begin
            imem[a] = progTable[a];
        end
        // reset low over four rising edges, released on the fourth
        for (int i = 0; i < 4; i++) begin
            @(posedge clock);
            if (i == 3) begin
                rstN <= 1'b1;
            end
            @(negedge clock);
            checkFetch(imemAddr, '0);
            verifyWren(dmemWren, 1'b0);
        end
        // straight-line fetch until the first load can stall
        for (int c = 1; c < FETCH_CHECKS; c++) begin
            @(negedge clock);
            checkFetch(imemAddr, word_t'(c));
        end
        for (int i = 0; i < NUM_STORES; i++) begin
            waited = 0;
            while (addrQ.size() == 0 && waited < STORE_TIMEOUT) begin
                @(posedge clock);
                waited++;
            end
            if (addrQ.size() == 0) begin
                $display("timeout: store %0d never appeared on the data bus", i);
                abortRun();
            end else begin
                gotAddr = addrQ.pop_front();
                gotData = dataQ.pop_front();
                checkStore(gotAddr, gotData, expAddr[i], expData[i]);
            end
        end
        // the final self-jump must stay quiet
        repeat (TAIL_CYCLES) @(posedge clock);
        if (addrQ.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("unexpected store to %h after the last expected one", addrQ[0]);
            abortRun();
        end
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
cpuPkg.sv
pcFetch.sv
instrDecode.sv
regFile.sv
executeStage.sv
memWriteback.sv
hazardUnit.sv
cpuCore.sv
cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module cpuTb -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VcpuTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -qx 'All tests passed!' "$LOG"; then
    exit 0
fi
exit 1
